//--- hw/opn_bus_pkg.sv
package opn_bus_pkg;

    // Host side register number and value
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // Timer register map, bank 0
    localparam reg_addr_t REG_TA_HI = 8'h24;  // Timer A bits 9..2
    localparam reg_addr_t REG_TA_LO = 8'h25;  // Timer A bits 1..0
    localparam reg_addr_t REG_TB    = 8'h26;
    localparam reg_addr_t REG_CTRL  = 8'h27;  // Load, enable and flag reset bits

    // Chip stays busy this long after every accepted data write
    localparam int BUSY_CYCLES = 32;
    localparam int BUSY_W      = $clog2(BUSY_CYCLES + 1);

    typedef logic [BUSY_W-1:0] busy_cnt_t;

    typedef enum logic [1:0] {
        ST_IDLE,    // No address pending
        ST_ADDR,    // Address latched, waiting for data
        ST_BUSY     // Write in progress
    } bus_state_t;

    // One register write, valid for one cycle
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        reg_data_t data;
    } reg_wr_t;

endpackage

//--- hw/opn_timer_pkg.sv
package opn_timer_pkg;

    localparam int TICK_DIV    = 6;   // Clocks per timer tick
    localparam int TB_PRESCALE = 16;  // Ticks per timer B count

    localparam int TICK_W = $clog2(TICK_DIV);
    localparam int TBPR_W = $clog2(TB_PRESCALE);

    typedef logic [9:0]        ta_value_t;
    typedef logic [7:0]        tb_value_t;
    typedef logic [TICK_W-1:0] tick_cnt_t;
    typedef logic [TBPR_W-1:0] tb_pre_t;

    // Programmed timer settings held by registers
    typedef struct packed {
        ta_value_t value_a;
        tb_value_t value_b;
        logic      load_a;
        logic      load_b;
        logic      irq_en_a;
        logic      irq_en_b;
    } timer_cfg_t;

    // Flag reset strobes, one cycle each
    typedef struct packed {
        logic clr_a;
        logic clr_b;
    } flag_clr_t;

endpackage

//--- hw/opn_bus_fsm.sv
`timescale 1ns/1ps

module opn_bus_fsm
    import opn_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  reg_data_t  din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output reg_wr_t    reg_wr,
    output logic       busy
);

    bus_state_t state;
    bus_state_t state_nx;
    busy_cnt_t  busy_cnt;
    reg_addr_t  addr_q;     // Latched register number
    logic       bank_q;     // Bank of the latched address
    logic       strobe;
    logic       addr_wr;
    logic       data_wr;
    logic       accept;

    assign strobe  = !cs_n && !wr_n;
    assign addr_wr = strobe && !addr[0];
    assign data_wr = strobe && addr[0];
    assign busy    = (state == ST_BUSY);

    // Only a bank 0 data write with a bank 0 address pending gets through
    assign accept = (state == ST_ADDR) && data_wr && !addr[1] && !bank_q;

    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE: begin
                if (addr_wr) begin
                    state_nx = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (accept) begin
                    state_nx = ST_BUSY;
                end else if (data_wr) begin
                    state_nx = ST_IDLE;  // Bank 1 data, address is used up
                end
            end
            ST_BUSY: begin
                if (busy_cnt == '0) begin
                    state_nx = ST_IDLE;
                end
            end
            default: state_nx = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            busy_cnt <= '0;
            addr_q   <= '0;
            bank_q   <= 1'b0;
            reg_wr   <= '0;
        end else begin
            state <= state_nx;

            // A later address write simply replaces the pending one
            if (addr_wr && !busy) begin
                addr_q <= din;
                bank_q <= addr[1];
            end

            if (accept) begin
                busy_cnt <= busy_cnt_t'(BUSY_CYCLES - 1);
            end else if (busy && busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end

            reg_wr.valid <= accept;
            if (accept) begin
                reg_wr.addr <= addr_q;
                reg_wr.data <= din;
            end
        end
    end

    a_busy_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        busy_cnt <= busy_cnt_t'(BUSY_CYCLES));

    // A strobe seen while busy never turns into a register write
    a_no_wr_from_busy: assert property (@(posedge clk) disable iff (!rst_n)
        reg_wr.valid |-> !$past(busy));

endmodule

//--- hw/opn_regs.sv
`timescale 1ns/1ps

module opn_regs
    import opn_bus_pkg::*;
    import opn_timer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  reg_wr_t    reg_wr,
    output timer_cfg_t timer_cfg,
    output flag_clr_t  flag_clr
);

    reg_data_t wr_data;

    assign wr_data = reg_wr.data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_cfg <= '0;
            flag_clr  <= '0;
        end else begin
            flag_clr <= '0;  // Strobes last one cycle
            if (reg_wr.valid) begin
                case (reg_wr.addr)
                    REG_TA_HI: timer_cfg.value_a[9:2] <= wr_data;
                    REG_TA_LO: timer_cfg.value_a[1:0] <= wr_data[1:0];
                    REG_TB:    timer_cfg.value_b      <= wr_data;
                    REG_CTRL: begin
                        timer_cfg.load_a   <= wr_data[0];
                        timer_cfg.load_b   <= wr_data[1];
                        timer_cfg.irq_en_a <= wr_data[2];
                        timer_cfg.irq_en_b <= wr_data[3];
                        // Flag resets are not stored
                        flag_clr.clr_a <= wr_data[4];
                        flag_clr.clr_b <= wr_data[5];
                    end
                    default: ;  // Other registers live outside this section
                endcase
            end
        end
    end

endmodule

//--- hw/opn_timers.sv
`timescale 1ns/1ps

module opn_timers
    import opn_timer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  timer_cfg_t timer_cfg,
    input  flag_clr_t  flag_clr,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);

    tick_cnt_t tick_cnt;
    logic      tick;
    ta_value_t cnt_a;
    tb_value_t cnt_b;
    tb_pre_t   pre_b;      // Ticks within one timer B count
    logic      load_a_q;
    logic      load_b_q;
    logic      start_a;
    logic      start_b;
    logic      run_a;
    logic      run_b;
    logic      step_b;
    logic      ovf_a;
    logic      ovf_b;

    // Free running tick every TICK_DIV clocks
    assign tick = (tick_cnt == tick_cnt_t'(TICK_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Rising load bit restarts the timer
    assign start_a = timer_cfg.load_a && !load_a_q;
    assign start_b = timer_cfg.load_b && !load_b_q;
    assign run_a   = timer_cfg.load_a && !start_a && tick;
    assign run_b   = timer_cfg.load_b && !start_b && tick;

    assign step_b = run_b && (pre_b == tb_pre_t'(TB_PRESCALE - 1));
    assign ovf_a  = run_a && (cnt_a == '1);
    assign ovf_b  = step_b && (cnt_b == '1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_a_q <= 1'b0;
            load_b_q <= 1'b0;
            cnt_a    <= '0;
            cnt_b    <= '0;
            pre_b    <= '0;
        end else begin
            load_a_q <= timer_cfg.load_a;
            load_b_q <= timer_cfg.load_b;

            if (start_a || ovf_a) begin
                cnt_a <= timer_cfg.value_a;  // Reload on start and wrap
            end else if (run_a) begin
                cnt_a <= cnt_a + 1'b1;
            end

            if (start_b || step_b) begin
                pre_b <= '0;
            end else if (run_b) begin
                pre_b <= pre_b + 1'b1;
            end

            if (start_b || ovf_b) begin
                cnt_b <= timer_cfg.value_b;
            end else if (step_b) begin
                cnt_b <= cnt_b + 1'b1;
            end
        end
    end

    // Overflow with interrupt disabled leaves the flag alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (flag_clr.clr_a) begin
                flag_a <= 1'b0;
            end else if (ovf_a && timer_cfg.irq_en_a) begin
                flag_a <= 1'b1;
            end
            if (flag_clr.clr_b) begin
                flag_b <= 1'b0;
            end else if (ovf_b && timer_cfg.irq_en_b) begin
                flag_b <= 1'b1;
            end
        end
    end

    assign irq_n = !(flag_a || flag_b);

    a_irq_needs_flag: assert property (@(posedge clk) disable iff (!rst_n)
        !irq_n |-> (flag_a || flag_b));

endmodule

//--- hw/opn_timer_top.sv
`timescale 1ns/1ps

module opn_timer_top
    import opn_bus_pkg::*;
    import opn_timer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  reg_data_t  din,
    input  logic [1:0] addr,
    input  logic       cs_n,
    input  logic       wr_n,
    output reg_data_t  dout,
    output logic       irq_n
);

    reg_wr_t    reg_wr;
    timer_cfg_t timer_cfg;
    flag_clr_t  flag_clr;
    logic       busy;
    logic       flag_a;
    logic       flag_b;

    opn_bus_fsm u_bus_fsm (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .din    ( din    ),
        .addr   ( addr   ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .reg_wr ( reg_wr ),
        .busy   ( busy   )
    );

    opn_regs u_regs (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .reg_wr    ( reg_wr    ),
        .timer_cfg ( timer_cfg ),
        .flag_clr  ( flag_clr  )
    );

    opn_timers u_timers (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .timer_cfg ( timer_cfg ),
        .flag_clr  ( flag_clr  ),
        .flag_a    ( flag_a    ),
        .flag_b    ( flag_b    ),
        .irq_n     ( irq_n     )
    );

    // Status byte, readable at any time
    assign dout = {busy, 5'b00000, flag_b, flag_a};

endmodule

//--- tests/tb_opn_timer_top.sv
`timescale 1ns/1ps

module tb_opn_timer_top
    import opn_bus_pkg::*;
    import opn_timer_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_TESTS    = 6;
    localparam int MAX_B_CLOCKS = TICK_DIV * TB_PRESCALE * 256;

    localparam reg_data_t CTRL_STOP   = 8'h30;  // Loads off, both flags cleared
    localparam reg_data_t CTRL_RUN_A  = 8'h05;
    localparam reg_data_t CTRL_RUN_B  = 8'h0a;
    localparam reg_data_t CTRL_FREE_A = 8'h01;  // Timer A runs with its interrupt masked
    localparam reg_data_t CTRL_CLR_A  = 8'h14;  // Clear flag A and hold timer A

    logic       clk;
    logic       rst_n;
    reg_data_t  din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    reg_data_t  dout;
    logic       irq_n;

    integer      seed;
    logic [31:0] rnd;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          errors_at_start;
    int          cycles;
    ta_value_t   value_a;
    tb_value_t   value_b;

    opn_timer_top u_opn_timer_top (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .din   ( din   ),
        .addr  ( addr  ),
        .cs_n  ( cs_n  ),
        .wr_n  ( wr_n  ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Clocks from load write to overflow
    function automatic int expected_period(input logic timer_b, input int value);
        if (timer_b) begin
            return TICK_DIV * TB_PRESCALE * (256 - value);
        end else begin
            return TICK_DIV * (1024 - value);
        end
    endfunction

    task automatic check_value(input string name, input int actual, input int expected,
                               input int tol);
        int diff;
        diff = actual - expected;
        if (diff < 0) begin
            diff = -diff;
        end
        if (diff > tol) begin
            $display("MISMATCH at %0t ns: %s is %0d, expected %0d (tolerance %0d)",
                     $time, name, actual, expected, tol);
            errors++;
        end
    endtask

    // One host strobe, called on a falling edge
    task automatic bus_strobe(input logic [1:0] a, input reg_data_t d);
        addr = a;
        din  = d;
        cs_n = 1'b0;
        wr_n = 1'b0;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (dout[7] && n <= BUSY_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (dout[7]) begin
            $display("ERROR at %0t ns: busy bit never cleared", $time);
            errors++;
        end
    endtask

    task automatic write_reg(input reg_addr_t r, input reg_data_t d);
        wait_idle();
        bus_strobe(2'b00, r);
        bus_strobe(2'b01, d);
    endtask

    task automatic set_value_a(input ta_value_t v);
        write_reg(REG_TA_HI, v[9:2]);
        write_reg(REG_TA_LO, {6'b000000, v[1:0]});
    endtask

    // Counts clocks since the last data strobe until the flag shows in dout
    task automatic check_period(input logic timer_b, input int value, input string name);
        int   expected;
        int   n;
        logic found;
        expected = expected_period(timer_b, value);
        n        = 0;
        found    = timer_b ? dout[1] : dout[0];
        while (!found && n < expected + 2 * TICK_DIV) begin
            @(negedge clk);
            n++;
            found = timer_b ? dout[1] : dout[0];
        end
        if (!found) begin
            $display("ERROR at %0t ns: %s flag did not rise within %0d clocks",
                     $time, name, n);
            errors++;
        end else begin
            check_value(name, n, expected, TICK_DIV);  // Tick phase is unknown
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        errors_at_start = errors;
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        din             = '0;
        addr            = 2'b00;
        cs_n            = 1'b1;
        wr_n            = 1'b1;
        seed            = 95;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_value("dout", int'(dout), 0, 0);
        check_value("irq_n", int'(irq_n), 1, 0);
        end_test("reset state");

        rnd     = $random(seed);
        value_a = rnd[9:0];
        write_reg(REG_TA_HI, value_a[9:2]);
        cycles = 0;
        while (dout[7] && cycles < 2 * BUSY_CYCLES) begin
            cycles++;
            @(negedge clk);
        end
        check_value("busy cycles", cycles, BUSY_CYCLES, 0);
        write_reg(REG_TA_LO, {6'b000000, value_a[1:0]});
        bus_strobe(2'b00, REG_TA_HI);                // Lands in the busy window
        bus_strobe(2'b01, value_a[9:2] ^ 8'h80);
        write_reg(REG_CTRL, CTRL_RUN_A);
        check_period(1'b0, int'(value_a), "timer A period");
        end_test("busy window");

        write_reg(REG_CTRL, CTRL_STOP);
        rnd     = $random(seed);
        value_a = rnd[9:0];
        set_value_a(value_a);
        write_reg(REG_CTRL, CTRL_RUN_A);
        check_period(1'b0, int'(value_a), "timer A period");
        check_value("irq_n", int'(irq_n), 0, 0);
        end_test("timer A");

        write_reg(REG_CTRL, CTRL_STOP);
        rnd     = $random(seed);
        value_b = rnd[7:0];
        write_reg(REG_TB, value_b);
        write_reg(REG_CTRL, CTRL_RUN_B);
        check_period(1'b1, int'(value_b), "timer B period");
        check_value("irq_n", int'(irq_n), 0, 0);
        end_test("timer B");

        write_reg(REG_CTRL, CTRL_STOP);
        rnd     = $random(seed);
        value_a = rnd[9:0];
        set_value_a(value_a);
        write_reg(REG_CTRL, CTRL_FREE_A);
        repeat (expected_period(1'b0, int'(value_a)) + 2 * TICK_DIV) @(negedge clk);
        check_value("flag_a", int'(dout[0]), 0, 0);
        check_value("irq_n", int'(irq_n), 1, 0);
        write_reg(REG_CTRL, CTRL_STOP);
        write_reg(REG_CTRL, CTRL_RUN_A);
        check_period(1'b0, int'(value_a), "timer A period");
        write_reg(REG_CTRL, CTRL_CLR_A);
        wait_idle();
        check_value("flag_a", int'(dout[0]), 0, 0);
        check_value("irq_n", int'(irq_n), 1, 0);
        end_test("mask and clear");

        write_reg(REG_CTRL, CTRL_STOP);
        rnd     = $random(seed);
        value_a = rnd[9:0];
        set_value_a(value_a);
        wait_idle();
        bus_strobe(2'b10, REG_TA_HI);
        bus_strobe(2'b11, ~value_a[9:2]);
        check_value("busy", int'(dout[7]), 0, 0);   // Bank 1 data never starts busy
        bus_strobe(2'b10, REG_TA_LO);
        bus_strobe(2'b11, {6'b000000, ~value_a[1:0]});
        write_reg(REG_CTRL, CTRL_RUN_A);
        check_period(1'b0, int'(value_a), "timer A period");
        end_test("bank 1 writes");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Worst case timer B period for every test, with margin
    initial begin : watchdog
        #(2 * NUM_TESTS * MAX_B_CLOCKS * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- flist.f
hw/opn_bus_pkg.sv
hw/opn_timer_pkg.sv
hw/opn_bus_fsm.sv
hw/opn_regs.sv
hw/opn_timers.sv
hw/opn_timer_top.sv
tests/tb_opn_timer_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

TOP=tb_opn_timer_top
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -o "sim_$TOP" \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

OUTPUT=$("./$BUILD_DIR/sim_$TOP")
STATUS=$?
echo "$OUTPUT"
if [ $STATUS -ne 0 ]; then
    echo "Simulation exited with status $STATUS"
    exit 1
fi

if echo "$OUTPUT" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
echo "Pass message not found"
exit 1
